//--- riscv_pipelined.f
source/riscv_isa_pkg.sv
source/pipeline_pkg.sv
source/fetch.sv
source/decode.sv
source/execute.sv
source/write_back.sv
source/riscv_pipelined.sv
dv/riscv_ref_model.sv
dv/riscv_pipelined_tb.sv

//--- Makefile
# verilator flow for the pipelined core, override any variable on the command line
VERILATOR   ?= verilator
TB_TOP      ?= riscv_pipelined_tb
RTL_TOP     ?= riscv_pipelined
FILE_LIST   ?= riscv_pipelined.f
BUILD_DIR   ?= obj_dir
LOG_FILE    ?= sim.log
FAIL_TEXT   ?= Simulation finished: FAIL
PASS_TEXT   ?= Simulation finished: PASS
VFLAGS      ?=
RTL_SOURCES ?= source/riscv_isa_pkg.sv source/pipeline_pkg.sv source/fetch.sv \
               source/decode.sv source/execute.sv source/write_back.sv \
               source/riscv_pipelined.sv

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) $(RTL_SOURCES)
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(TB_TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TB_TOP) -f $(FILE_LIST) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG_FILE)
	@if grep -q "$(FAIL_TEXT)" $(LOG_FILE); then echo "sim failed, see $(LOG_FILE)"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG_FILE); then echo "sim did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG_FILE)

//--- dv/riscv_pipelined_tb.sv
`timescale 1ns/1ps
`default_nettype none

// random program run on the core, stores checked against the model
module riscv_pipelined_tb;

  import riscv_isa_pkg::*;
  import riscv_ref_model::*;

  localparam int IMEM_WORDS     = 512;
  localparam int RESET_CYCLES   = 5;
  localparam int TIMEOUT_CYCLES = PROGRAM_LEN + 50;
  // last program word plus pipeline depth and one spare slot
  localparam addr_t END_ADDRESS = addr_t'((PROGRAM_LEN + 4) * 4);

  logic     clk = 1'b0;
  logic     reset = 1'b1;
  addr_t    imem_address;
  data_t    imem_write_data;
  byte_en_t imem_write_enable;
  data_t    imem_read_data;
  addr_t    dmem_address;
  data_t    dmem_write_data;
  byte_en_t dmem_write_enable;
  data_t    dmem_read_data;

  instr_t imem [IMEM_WORDS];
  data_t  dmem [DMEM_WORDS];

  int    error_count = 0;
  int    check_count = 0;
  int    store_count = 0;
  int    run_cycles = 0;
  int    cycles_out_of_reset = 0;
  addr_t expected_pc = RESET_PC;

  always #4 clk = ~clk;

  riscv_pipelined riscv_pipelined_inst
    ( .clk                        ( clk               )
    , .reset                      ( reset             )
    , .memory_instr__address      ( imem_address      )
    , .memory_instr__write_data   ( imem_write_data   )
    , .memory_instr__write_enable ( imem_write_enable )
    , .memory_instr__read_data    ( imem_read_data    )
    , .memory_data__address       ( dmem_address      )
    , .memory_data__write_data    ( dmem_write_data   )
    , .memory_data__write_enable  ( dmem_write_enable )
    , .memory_data__read_data     ( dmem_read_data    )
    );

  // combinational reads on both ports
  assign imem_read_data = imem[imem_address[10:2]];
  assign dmem_read_data = dmem[dmem_address[9:2]];

  // byte-masked writes on the clock edge
  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (dmem_write_enable[b]) begin
        dmem[dmem_address[9:2]][8*b +: 8] <= dmem_write_data[8*b +: 8];
      end
    end
  end

  task automatic check_value(input string name, input data_t actual, input data_t expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h at %0t",
               name, actual, expected, $time);
    end
  endtask

  // next store in program order
  task automatic compare_store();
    store_rec_t expected;
    store_count++;
    if (expected_stores.size() == 0) begin
      error_count++;
      $display("unexpected store to 0x%08h after all expected stores were seen", dmem_address);
    end else begin
      expected = expected_stores.pop_front();
      check_value("memory_data__address", dmem_address, expected.address);
      check_value("memory_data__write_data", dmem_write_data, expected.data);
      check_value("memory_data__write_enable", data_t'(dmem_write_enable),
                  data_t'(expected.mask));
    end
  endtask

  task automatic print_counts();
    $display("checks %0d, stores %0d, errors %0d", check_count, store_count, error_count);
  endtask

  // mid-cycle sampling, bus is settled at the falling edge
  always @(negedge clk) begin
    // instruction port never writes
    check_value("memory_instr__write_enable", data_t'(imem_write_enable), '0);
    check_value("memory_instr__write_data", imem_write_data, '0);
    if (reset || cycles_out_of_reset == 0) begin
      // nothing may reach the data port yet
      check_value("memory_data__write_enable", data_t'(dmem_write_enable), '0);
    end else if (dmem_write_enable != '0) begin
      compare_store();
    end
    if (reset) begin
      expected_pc = RESET_PC;
    end else begin
      // sequential fetch from reset pc
      check_value("memory_instr__address", imem_address, expected_pc);
      expected_pc = expected_pc + addr_t'(4);
      cycles_out_of_reset++;
    end
  end

  // run limit counted from reset release
  always @(posedge clk) begin
    if (!reset) begin
      run_cycles = run_cycles + 1;
      if (run_cycles > TIMEOUT_CYCLES) begin
        $display("timeout: program not drained after %0d cycles", TIMEOUT_CYCLES);
        print_counts();
        $display("Simulation finished: FAIL");
        $finish;
      end
    end
  end

  initial begin
    void'($urandom(25));
    generate_program();
    // program then nops
    for (int w = 0; w < IMEM_WORDS; w++) begin
      imem[w] = (w < PROGRAM_LEN) ? program_words[w] : NOP;
    end
    for (int w = 0; w < DMEM_WORDS; w++) begin
      dmem[w] <= fill_word(addr_t'(w * 4));
    end
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
    // pc past the last word plus the pipeline
    while (imem_address < END_ADDRESS) begin
      @(negedge clk);
    end
    @(posedge clk);
    if (expected_stores.size() != 0) begin
      error_count++;
      $display("%0d expected stores never reached the data port", expected_stores.size());
    end
    print_counts();
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/riscv_ref_model.sv
`default_nettype none

// instruction-level model of the rv32i subset and a random program generator
package riscv_ref_model;

  import riscv_isa_pkg::*;

  localparam int PROGRAM_LEN = 200;
  // data accesses stay in a small window so loads hit earlier stores
  localparam int MEM_SPAN   = 64;
  localparam int DMEM_WORDS = 256;
  localparam reg_idx_t BASE_REG   = 5'd30;
  localparam data_t    BASE_VALUE = 32'h0000_0020;
  // addi x0, x0, 0
  localparam instr_t   NOP = 32'h0000_0013;

  localparam funct3_t REG_FUNCT3 [7] = '{FUNCT3_ADD_SUB, FUNCT3_SLL, FUNCT3_SLT, FUNCT3_XOR,
                                         FUNCT3_SRL, FUNCT3_OR, FUNCT3_AND};
  localparam funct3_t IMM_FUNCT3 [4] = '{FUNCT3_ADD_SUB, FUNCT3_XOR, FUNCT3_OR, FUNCT3_AND};
  localparam funct3_t STORE_FUNCT3 [3] = '{FUNCT3_SB, FUNCT3_SH, FUNCT3_SW};

  // one store as it should appear on the data port
  typedef struct packed {
    addr_t    address;
    data_t    data;
    byte_en_t mask;
  } store_rec_t;

  instr_t     program_words [PROGRAM_LEN];
  store_rec_t expected_stores [$];
  data_t      model_regs [32];
  data_t      model_mem [DMEM_WORDS];

  // initial memory content, hashed from the whole byte address
  function automatic data_t fill_word(input addr_t address);
    return (address * 32'h9E37_79B9) ^ 32'h5A5A_C3C3;
  endfunction

  function automatic instr_t encode_r(input funct7_t f7, input reg_idx_t rs2,
                                      input reg_idx_t rs1, input funct3_t f3, input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPCODE_OP};
  endfunction

  function automatic instr_t encode_i(input opcode_t op, input logic [11:0] imm,
                                      input reg_idx_t rs1, input funct3_t f3, input reg_idx_t rd);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic instr_t encode_s(input logic [11:0] imm, input reg_idx_t rs2,
                                      input reg_idx_t rs1, input funct3_t f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPCODE_STORE};
  endfunction

  // isa semantics of the alu ops
  function automatic data_t compute_alu(input funct3_t f3, input logic sub,
                                        input data_t a, input data_t b);
    case (f3)
      FUNCT3_ADD_SUB: return sub ? a - b : a + b;
      FUNCT3_SLL:     return a << b[4:0];
      FUNCT3_SLT:     return {31'b0, $signed(a) < $signed(b)};
      FUNCT3_XOR:     return a ^ b;
      FUNCT3_SRL:     return a >> b[4:0];
      FUNCT3_OR:      return a | b;
      default:        return a & b;
    endcase
  endfunction

  // any register except the one written just before
  function automatic reg_idx_t pick_source(input reg_idx_t prev_rd);
    reg_idx_t idx;
    idx = reg_idx_t'($urandom_range(0, 31));
    while (idx != '0 && idx == prev_rd) begin
      idx = reg_idx_t'($urandom_range(0, 31));
    end
    return idx;
  endfunction

  // x0 ignores writes
  task automatic write_reg(input reg_idx_t rd, input data_t value);
    if (rd != '0) begin
      model_regs[rd] = value;
    end
  endtask

  // each lane repeats the value, enabled lanes run from the aligned offset
  task automatic record_store(input addr_t address, input data_t value, input funct3_t f3);
    store_rec_t rec;
    int         size;
    int         first;
    case (f3)
      FUNCT3_SB: size = 1;
      FUNCT3_SH: size = 2;
      default:   size = 4;
    endcase
    first       = int'(address[1:0]) & ~(size - 1);
    rec.address = address;
    for (int b = 0; b < 4; b++) begin
      rec.data[8*b +: 8] = value[8*(b % size) +: 8];
      rec.mask[b]        = (b >= first) && (b < first + size);
      if (rec.mask[b]) begin
        model_mem[address[9:2]][8*b +: 8] = rec.data[8*b +: 8];
      end
    end
    expected_stores.push_back(rec);
  endtask

  // builds the program and runs each word on the model as it goes
  task automatic generate_program();
    reg_idx_t    prev_rd;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    funct3_t     f3;
    logic        sub;
    logic [11:0] imm;
    logic [19:0] upper;
    data_t       imm_ext;
    addr_t       address;
    int          kind;
    int          pick;
    int          offset;
    for (int r = 0; r < 32; r++) begin
      model_regs[r] = '0;
    end
    for (int w = 0; w < DMEM_WORDS; w++) begin
      model_mem[w] = fill_word(addr_t'(w * 4));
    end
    expected_stores.delete();
    // a store at the reset pc would leak onto the data port if reset left a stage live
    program_words[0] = encode_s(12'd0, 5'd0, 5'd0, FUNCT3_SW);
    record_store(addr_t'(0), '0, FUNCT3_SW);
    // second word sets the base register for memory accesses
    program_words[1] = encode_i(OPCODE_OP_IMM, BASE_VALUE[11:0], 5'd0, FUNCT3_ADD_SUB, BASE_REG);
    model_regs[BASE_REG] = BASE_VALUE;
    prev_rd = BASE_REG;
    for (int i = 2; i < PROGRAM_LEN; i++) begin
      kind    = int'($urandom_range(0, 9));
      // x30 keeps the base, x31 stays zero
      rd      = reg_idx_t'($urandom_range(0, 29));
      rs1     = pick_source(prev_rd);
      rs2     = pick_source(prev_rd);
      imm     = 12'($urandom);
      imm_ext = {{20{imm[11]}}, imm};
      if (kind <= 2) begin
        pick = int'($urandom_range(0, 6));
        f3   = REG_FUNCT3[pick[2:0]];
        sub  = (f3 == FUNCT3_ADD_SUB) && ($urandom_range(0, 1) == 1);
        program_words[i] = encode_r(sub ? FUNCT7_SUB : FUNCT7_ZERO, rs2, rs1, f3, rd);
        write_reg(rd, compute_alu(f3, sub, model_regs[rs1], model_regs[rs2]));
      end else if (kind <= 4) begin
        pick = int'($urandom_range(0, 3));
        f3   = IMM_FUNCT3[pick[1:0]];
        program_words[i] = encode_i(OPCODE_OP_IMM, imm, rs1, f3, rd);
        write_reg(rd, compute_alu(f3, 1'b0, model_regs[rs1], imm_ext));
      end else if (kind == 5) begin
        upper = 20'($urandom);
        program_words[i] = {upper, rd, OPCODE_LUI};
        write_reg(rd, {upper, 12'b0});
      end else begin
        // base is x0 or x30, imm lands the address in the window
        rs1    = (prev_rd != BASE_REG && $urandom_range(0, 1) == 1) ? BASE_REG : reg_idx_t'(0);
        pick   = int'($urandom_range(0, 2));
        f3     = (kind == 6) ? FUNCT3_LW : STORE_FUNCT3[pick[1:0]];
        offset = int'($urandom_range(0, MEM_SPAN - 1));
        // lw shares funct3 with sw so both align to words
        if (f3 == FUNCT3_SW) begin
          offset = offset & ~3;
        end else if (f3 == FUNCT3_SH) begin
          offset = offset & ~1;
        end
        imm     = 12'(offset - int'(model_regs[rs1]));
        imm_ext = {{20{imm[11]}}, imm};
        address = model_regs[rs1] + imm_ext;
        if (kind == 6) begin
          program_words[i] = encode_i(OPCODE_LOAD, imm, rs1, FUNCT3_LW, rd);
          write_reg(rd, model_mem[address[9:2]]);
        end else begin
          program_words[i] = encode_s(imm, rs2, rs1, f3);
          record_store(address, model_regs[rs2], f3);
          // stores produce nothing
          rd = '0;
        end
      end
      prev_rd = rd;
    end
  endtask

endpackage

`default_nettype wire

//--- source/riscv_pipelined.sv
`timescale 1ns/1ps
`default_nettype none

// four stage in-order rv32i subset core
module riscv_pipelined
  ( input  logic                     clk
  , input  logic                     reset

  // instruction memory
  , output riscv_isa_pkg::addr_t     memory_instr__address
  , output riscv_isa_pkg::data_t     memory_instr__write_data
  , output riscv_isa_pkg::byte_en_t  memory_instr__write_enable
  , input  riscv_isa_pkg::data_t     memory_instr__read_data

  // data memory
  , output riscv_isa_pkg::addr_t     memory_data__address
  , output riscv_isa_pkg::data_t     memory_data__write_data
  , output riscv_isa_pkg::byte_en_t  memory_data__write_enable
  , input  riscv_isa_pkg::data_t     memory_data__read_data
  );

  import riscv_isa_pkg::*;
  import pipeline_pkg::*;

  if_to_id_t if_to_id_out;
  if_to_id_t if_to_id_reg;
  id_to_ex_t id_to_ex_out;
  id_to_ex_t id_to_ex_reg;
  ex_to_wb_t ex_to_wb_out;
  ex_to_wb_t ex_to_wb_reg;

  // write back to register file
  data_t    wb_result;
  reg_idx_t wb_rd;
  logic     wb_write;

  // instruction port is read only
  assign memory_instr__write_data   = '0;
  assign memory_instr__write_enable = '0;

  fetch fetch_inst
    ( .clk           ( clk                     )
    , .reset         ( reset                   )
    , .instr_address ( memory_instr__address   )
    , .instr_data    ( memory_instr__read_data )
    , .if_to_id      ( if_to_id_out            )
    );

  decode decode_inst
    ( .clk       ( clk          )
    , .reset     ( reset        )
    , .if_to_id  ( if_to_id_reg )
    , .wb_result ( wb_result    )
    , .wb_rd     ( wb_rd        )
    , .wb_write  ( wb_write     )
    , .id_to_ex  ( id_to_ex_out )
    );

  execute execute_inst
    ( .id_to_ex          ( id_to_ex_reg              )
    , .data_address      ( memory_data__address      )
    , .data_write_data   ( memory_data__write_data   )
    , .data_write_enable ( memory_data__write_enable )
    , .data_read_data    ( memory_data__read_data    )
    , .ex_to_wb          ( ex_to_wb_out              )
    );

  write_back write_back_inst
    ( .ex_to_wb  ( ex_to_wb_reg )
    , .result    ( wb_result    )
    , .rd        ( wb_rd        )
    , .reg_write ( wb_write     )
    );

  // stage registers, no stalls so they load every cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      if_to_id_reg <= '0;
      id_to_ex_reg <= '0;
      ex_to_wb_reg <= '0;
    end else begin
      if_to_id_reg <= if_to_id_out;
      id_to_ex_reg <= id_to_ex_out;
      ex_to_wb_reg <= ex_to_wb_out;
    end
  end

endmodule

`default_nettype wire

//--- source/write_back.sv
`timescale 1ns/1ps
`default_nettype none

// result select and register write request
module write_back
  ( input  pipeline_pkg::ex_to_wb_t  ex_to_wb
  , output riscv_isa_pkg::data_t     result
  , output riscv_isa_pkg::reg_idx_t  rd
  , output logic                     reg_write
  );

  import riscv_isa_pkg::*;

  logic rd_nonzero;

  // loads return memory data, everything else the alu
  assign result = ex_to_wb.mem_read ? ex_to_wb.load_data : ex_to_wb.alu_result;

  assign rd = ex_to_wb.rd;

  // writes to x0 are dropped here and nowhere else
  assign rd_nonzero = (ex_to_wb.rd != reg_idx_t'(0));

  // only live records that target a real register
  assign reg_write = ex_to_wb.valid && ex_to_wb.reg_write && rd_nonzero;

endmodule

`default_nettype wire

//--- source/execute.sv
`timescale 1ns/1ps
`default_nettype none

// alu, data memory access and load capture
module execute
  ( input  pipeline_pkg::id_to_ex_t  id_to_ex
  , output riscv_isa_pkg::addr_t     data_address
  , output riscv_isa_pkg::data_t     data_write_data
  , output riscv_isa_pkg::byte_en_t  data_write_enable
  , input  riscv_isa_pkg::data_t     data_read_data
  , output pipeline_pkg::ex_to_wb_t  ex_to_wb
  );

  import riscv_isa_pkg::*;
  import pipeline_pkg::*;

  data_t      operand_a;
  data_t      operand_b;
  data_t      alu_result;
  logic [4:0] shamt;
  logic [1:0] byte_offset;
  byte_en_t   lane_mask;

  assign operand_a = id_to_ex.operand_a;
  assign operand_b = id_to_ex.operand_b;
  // shifts use the low five bits only
  assign shamt     = operand_b[4:0];

  always_comb begin
    alu_result = '0;
    case (id_to_ex.alu_op)
      ALU_ADD:    alu_result = operand_a + operand_b;
      ALU_SUB:    alu_result = operand_a - operand_b;
      ALU_AND:    alu_result = operand_a & operand_b;
      ALU_OR:     alu_result = operand_a | operand_b;
      ALU_XOR:    alu_result = operand_a ^ operand_b;
      ALU_SLT:    alu_result[0] = $signed(operand_a) < $signed(operand_b);
      ALU_SLL:    alu_result = operand_a << shamt;
      ALU_SRL:    alu_result = operand_a >> shamt;
      ALU_PASS_B: alu_result = operand_b;
      default:    alu_result = '0;
    endcase
  end

  // load and store address is rs1 plus the immediate
  assign data_address = alu_result;
  assign byte_offset  = alu_result[1:0];

  // replicate store data so every lane holds the value
  always_comb begin
    case (id_to_ex.store_size)
      STORE_BYTE: begin
        data_write_data = {4{id_to_ex.store_data[7:0]}};
        lane_mask       = byte_en_t'(4'b0001 << byte_offset);
      end
      STORE_HALF: begin
        data_write_data = {2{id_to_ex.store_data[15:0]}};
        // aligned halfword picks the upper or lower pair
        lane_mask       = byte_offset[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        data_write_data = id_to_ex.store_data;
        lane_mask       = 4'b1111;
      end
    endcase
  end

  // bubbles and non-stores never write
  assign data_write_enable = (id_to_ex.valid && id_to_ex.mem_write) ? lane_mask : '0;

  always_comb begin
    ex_to_wb.valid      = id_to_ex.valid;
    ex_to_wb.alu_result = alu_result;
    // combinational read lands in the same cycle
    ex_to_wb.load_data  = data_read_data;
    ex_to_wb.rd         = id_to_ex.rd;
    ex_to_wb.reg_write  = id_to_ex.reg_write;
    ex_to_wb.mem_read   = id_to_ex.mem_read;
  end

endmodule

`default_nettype wire

//--- source/decode.sv
`timescale 1ns/1ps
`default_nettype none

// instruction decode, immediates and register file
module decode
  ( input  logic                     clk
  , input  logic                     reset
  , input  pipeline_pkg::if_to_id_t  if_to_id
  , input  riscv_isa_pkg::data_t     wb_result
  , input  riscv_isa_pkg::reg_idx_t  wb_rd
  , input  logic                     wb_write
  , output pipeline_pkg::id_to_ex_t  id_to_ex
  );

  import riscv_isa_pkg::*;
  import pipeline_pkg::*;

  // x1 to x31 only
  data_t regs [1:31];

  instr_t   instr;
  opcode_t  opcode;
  funct3_t  funct3;
  funct7_t  funct7;
  reg_idx_t rs1;
  reg_idx_t rs2;
  data_t    rs1_data;
  data_t    rs2_data;
  data_t    imm_i;
  data_t    imm_s;
  data_t    imm_u;
  logic     legal;

  // instruction fields
  assign instr  = if_to_id.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // sign-extended immediates
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'b0};

  // register file starts from zero so programs see a known state
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_write) begin
      regs[wb_rd] <= wb_result;
    end
  end

  // read with write-through so a consumer two slots behind sees the result
  function automatic data_t read_reg(input reg_idx_t idx);
    data_t value;
    if (idx == reg_idx_t'(0)) begin
      value = '0;
    end else if (wb_write && wb_rd == idx) begin
      value = wb_result;
    end else begin
      value = regs[idx];
    end
    return value;
  endfunction

  always_comb begin
    rs1_data = read_reg(rs1);
    rs2_data = read_reg(rs2);
  end

  always_comb begin
    legal                = 1'b1;
    id_to_ex.alu_op      = ALU_ADD;
    id_to_ex.operand_a   = rs1_data;
    id_to_ex.operand_b   = rs2_data;
    id_to_ex.store_data  = rs2_data;
    id_to_ex.rd          = instr[11:7];
    id_to_ex.reg_write   = 1'b0;
    id_to_ex.mem_read    = 1'b0;
    id_to_ex.mem_write   = 1'b0;
    id_to_ex.store_size  = STORE_WORD;
    case (opcode)
      OPCODE_OP: begin
        id_to_ex.reg_write = 1'b1;
        // only sub carries a nonzero funct7
        legal = (funct7 == FUNCT7_ZERO) ||
                (funct7 == FUNCT7_SUB && funct3 == FUNCT3_ADD_SUB);
        case (funct3)
          FUNCT3_ADD_SUB: id_to_ex.alu_op = (funct7 == FUNCT7_SUB) ? ALU_SUB : ALU_ADD;
          FUNCT3_SLL:     id_to_ex.alu_op = ALU_SLL;
          FUNCT3_SLT:     id_to_ex.alu_op = ALU_SLT;
          FUNCT3_XOR:     id_to_ex.alu_op = ALU_XOR;
          FUNCT3_SRL:     id_to_ex.alu_op = ALU_SRL;
          FUNCT3_OR:      id_to_ex.alu_op = ALU_OR;
          FUNCT3_AND:     id_to_ex.alu_op = ALU_AND;
          // sltu not supported
          default:        legal = 1'b0;
        endcase
      end
      OPCODE_OP_IMM: begin
        id_to_ex.reg_write = 1'b1;
        id_to_ex.operand_b = imm_i;
        case (funct3)
          FUNCT3_ADD_SUB: id_to_ex.alu_op = ALU_ADD;
          FUNCT3_XOR:     id_to_ex.alu_op = ALU_XOR;
          FUNCT3_OR:      id_to_ex.alu_op = ALU_OR;
          FUNCT3_AND:     id_to_ex.alu_op = ALU_AND;
          default:        legal = 1'b0;
        endcase
      end
      OPCODE_LUI: begin
        id_to_ex.reg_write = 1'b1;
        id_to_ex.alu_op    = ALU_PASS_B;
        id_to_ex.operand_b = imm_u;
      end
      OPCODE_LOAD: begin
        // word loads only
        legal              = (funct3 == FUNCT3_LW);
        id_to_ex.reg_write = 1'b1;
        id_to_ex.mem_read  = 1'b1;
        id_to_ex.operand_b = imm_i;
      end
      OPCODE_STORE: begin
        id_to_ex.mem_write = 1'b1;
        id_to_ex.operand_b = imm_s;
        case (funct3)
          FUNCT3_SB: id_to_ex.store_size = STORE_BYTE;
          FUNCT3_SH: id_to_ex.store_size = STORE_HALF;
          FUNCT3_SW: id_to_ex.store_size = STORE_WORD;
          default:   legal = 1'b0;
        endcase
      end
      default: begin
        legal = 1'b0;
      end
    endcase
    // illegal words flow on as bubbles
    id_to_ex.valid = if_to_id.valid && legal;
  end

endmodule

`default_nettype wire

//--- source/fetch.sv
`timescale 1ns/1ps
`default_nettype none

// program counter and instruction fetch
module fetch
  ( input  logic                     clk
  , input  logic                     reset
  , output riscv_isa_pkg::addr_t     instr_address
  , input  riscv_isa_pkg::instr_t    instr_data
  , output pipeline_pkg::if_to_id_t  if_to_id
  );

  import riscv_isa_pkg::*;

  addr_t pc;
  addr_t pc_next;

  // no branches or jumps so the flow is purely sequential
  assign pc_next = pc + addr_t'(4);

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // combinational instruction memory read
  assign instr_address = pc;

  always_comb begin
    if_to_id.instr = instr_data;
    // live from the first cycle after reset
    if_to_id.valid = !reset;
  end

endmodule

`default_nettype wire

//--- source/pipeline_pkg.sv
`default_nettype none

// records passed between pipeline stages and the alu op encoding
package pipeline_pkg;

  // internal alu operation code
  typedef logic [3:0] alu_op_t;

  localparam alu_op_t ALU_ADD    = 4'd0;
  localparam alu_op_t ALU_SUB    = 4'd1;
  localparam alu_op_t ALU_AND    = 4'd2;
  localparam alu_op_t ALU_OR     = 4'd3;
  localparam alu_op_t ALU_XOR    = 4'd4;
  localparam alu_op_t ALU_SLT    = 4'd5;
  localparam alu_op_t ALU_SLL    = 4'd6;
  localparam alu_op_t ALU_SRL    = 4'd7;
  // lui just forwards the immediate
  localparam alu_op_t ALU_PASS_B = 4'd8;

  // width of a store access
  typedef logic [1:0] store_size_t;

  localparam store_size_t STORE_BYTE = 2'd0;
  localparam store_size_t STORE_HALF = 2'd1;
  localparam store_size_t STORE_WORD = 2'd2;

  // fetch to decode
  typedef struct packed {
    riscv_isa_pkg::instr_t instr;
    logic                  valid;
  } if_to_id_t;

  // decode to execute
  typedef struct packed {
    logic                    valid;
    alu_op_t                 alu_op;
    riscv_isa_pkg::data_t    operand_a;
    // immediate or rs2
    riscv_isa_pkg::data_t    operand_b;
    riscv_isa_pkg::data_t    store_data;
    riscv_isa_pkg::reg_idx_t rd;
    logic                    reg_write;
    logic                    mem_read;
    logic                    mem_write;
    store_size_t             store_size;
  } id_to_ex_t;

  // execute to write back
  typedef struct packed {
    logic                    valid;
    riscv_isa_pkg::data_t    alu_result;
    riscv_isa_pkg::data_t    load_data;
    riscv_isa_pkg::reg_idx_t rd;
    logic                    reg_write;
    logic                    mem_read;
  } ex_to_wb_t;

endpackage

`default_nettype wire

//--- source/riscv_isa_pkg.sv
`default_nettype none

// rv32i encodings and vector types shared by every stage
package riscv_isa_pkg;

  // widths that carry meaning in the isa
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [3:0]  byte_en_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;
  typedef logic [6:0]  funct7_t;

  // major opcodes in the supported subset
  localparam opcode_t OPCODE_OP     = 7'b0110011;
  localparam opcode_t OPCODE_OP_IMM = 7'b0010011;
  localparam opcode_t OPCODE_LUI    = 7'b0110111;
  localparam opcode_t OPCODE_LOAD   = 7'b0000011;
  localparam opcode_t OPCODE_STORE  = 7'b0100011;

  // alu funct3, shared by op and op-imm
  localparam funct3_t FUNCT3_ADD_SUB = 3'b000;
  localparam funct3_t FUNCT3_SLL     = 3'b001;
  localparam funct3_t FUNCT3_SLT     = 3'b010;
  localparam funct3_t FUNCT3_XOR     = 3'b100;
  localparam funct3_t FUNCT3_SRL     = 3'b101;
  localparam funct3_t FUNCT3_OR      = 3'b110;
  localparam funct3_t FUNCT3_AND     = 3'b111;

  // memory access funct3
  localparam funct3_t FUNCT3_LW = 3'b010;
  localparam funct3_t FUNCT3_SB = 3'b000;
  localparam funct3_t FUNCT3_SH = 3'b001;
  localparam funct3_t FUNCT3_SW = 3'b010;

  // funct7 for register-register ops
  localparam funct7_t FUNCT7_ZERO = 7'b0000000;
  localparam funct7_t FUNCT7_SUB  = 7'b0100000;

  // first fetch address after reset
  localparam addr_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire
